// File: logic/addr_trans.sv
`timescale 1ns/1ps

module addr_trans (
    input  fetch_pkg::word_t      va,
    input  fetch_pkg::csr_fetch_t csr,
    output fetch_pkg::word_t      pa,
    output logic                  is_cached,
    output fetch_pkg::excp_pass_t excp
);
    import fetch_pkg::*;

    logic [1:0] win_hit;
    logic       mapped_miss;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            win_hit[i] = csr.dmw[i].en && (csr.dmw[i].vseg == va[31:29]);
        end
    end

    always_comb begin
        pa          = va;
        is_cached   = 1'b1;  // direct mode fetches are cached.
        mapped_miss = 1'b0;
        if (!csr.da) begin
            if (win_hit[0]) begin
                pa        = {csr.dmw[0].pseg, va[28:0]};
                is_cached = csr.dmw[0].mat[0];
            end else if (win_hit[1]) begin
                pa        = {csr.dmw[1].pseg, va[28:0]};
                is_cached = csr.dmw[1].mat[0];
            end else begin
                is_cached   = 1'b0;
                mapped_miss = 1'b1;  // would need a tlb lookup.
            end
        end
    end

    // Alignment is checked first since it does not depend on the mapping.
    always_comb begin
        if (va[1:0] != 2'b00) begin
            excp.valid = 1'b1;
            excp.code  = EXC_ADEF;
        end else if (mapped_miss) begin
            excp.valid = 1'b1;
            excp.code  = EXC_TLBR;
        end else begin
            excp.valid = 1'b0;
            excp.code  = EXC_NONE;
        end
    end

endmodule

// File: logic/btb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module btb (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fetch_pkg::btb_update_t upd,
    btb_if.btb                     lookup
);
    import fetch_pkg::*;

    logic [`BTB_ENTRIES-1:0] entry_valid;
    word_t                   entry_pc     [`BTB_ENTRIES];
    word_t                   entry_target [`BTB_ENTRIES];

    logic [`BTB_IDX_W-1:0] upd_idx;
    logic [`BTB_IDX_W-1:0] lkp_idx;
    logic                  lkp_hit;

    logic  pred_valid_r;
    word_t pred_npc_r;

    assign upd_idx = upd.pc[`BTB_IDX_W+1:2];
    assign lkp_idx = lookup.pc[`BTB_IDX_W+1:2];

    // the full pc is stored so aliasing pcs never hit.
    assign lkp_hit = entry_valid[lkp_idx] && (entry_pc[lkp_idx] == lookup.pc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (upd.valid) begin
            entry_valid[upd_idx] <= 1'b1;
        end
    end

    // Table contents. A same-cycle lookup still reads the old entry.
    always_ff @(posedge clk) begin
        if (upd.valid) begin
            entry_pc[upd_idx]     <= upd.pc;
            entry_target[upd_idx] <= upd.target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_valid_r <= 1'b0;
            pred_npc_r   <= '0;
        end else if (!lookup.is_stall) begin
            pred_valid_r <= lkp_hit;
            pred_npc_r   <= entry_target[lkp_idx];  // only meaningful on a hit.
        end
    end

    assign lookup.pred_valid = pred_valid_r;
    assign lookup.pred_npc   = pred_npc_r;

endmodule

// File: logic/btb_if.sv
`timescale 1ns/1ps

interface btb_if;
    import fetch_pkg::*;

    logic  is_stall;
    word_t pc;          // pc to look up on the next edge.
    logic  pred_valid;
    word_t pred_npc;

    modport fetch (
        output is_stall,
        output pc,
        input  pred_valid,
        input  pred_npc
    );

    modport btb (
        input  is_stall,
        input  pc,
        output pred_valid,
        output pred_npc
    );
endinterface

// File: logic/fetch1.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch1 (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fetch_pkg::wr_pc_req_t  ex_wr_pc_req,
    input  fetch_pkg::wr_pc_req_t  excp_wr_pc_req,
    input  fetch_pkg::word_t       pa,
    input  logic                   is_cached,
    input  fetch_pkg::excp_pass_t  addr_excp,
    input  logic                   is_stall,
    input  logic                   is_flush,
    btb_if.fetch                   btb,
    output fetch_pkg::word_t       va,
    output logic [11:0]            icache_idx,
    output fetch_pkg::ic_op_t      icache_op,
    output fetch_pkg::word_t       icache_pa,
    output logic                   icache_is_cached,
    output fetch_pkg::fetch_pass_t pass_out,
    output fetch_pkg::excp_pass_t  excp_pass_out
);
    import fetch_pkg::*;

    word_t pc_r;
    word_t npc;

    // The btb prediction already belongs to pc_r since it was looked up with npc.
    always_comb begin
        if (excp_wr_pc_req.valid) begin
            npc = excp_wr_pc_req.pc;
        end else if (ex_wr_pc_req.valid) begin
            npc = ex_wr_pc_req.pc;
        end else if (btb.pred_valid) begin
            npc = btb.pred_npc;
        end else begin
            npc = pc_r + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_r <= `RESET_PC;
        end else if (!is_stall) begin
            pc_r <= npc;
        end
    end

    assign btb.pc       = npc;       // looked up on the same edge that loads pc_r.
    assign btb.is_stall = is_stall;  // the prediction freezes with the pc.

    assign va = pc_r;

    assign icache_idx       = pc_r[11:0];
    assign icache_op        = is_flush ? IC_NOP : IC_READ;
    assign icache_pa        = pa;
    assign icache_is_cached = is_cached;

    assign pass_out.is_flush = is_flush;
    assign pass_out.pc       = pc_r;
    assign pass_out.btb_pre  = npc;
    assign excp_pass_out     = addr_excp;

endmodule

// File: logic/fetch_front.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_front (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              flush,
    input  logic              ex_redirect_valid,
    input  logic [`INST_W-1:0] ex_redirect_pc,
    input  logic              excp_redirect_valid,
    input  logic [`INST_W-1:0] excp_redirect_pc,
    input  logic              btb_upd_valid,
    input  logic [`INST_W-1:0] btb_upd_pc,
    input  logic [`INST_W-1:0] btb_upd_target,
    input  logic              csr_da,
    input  logic              dmw0_en,
    input  logic [2:0]        dmw0_vseg,
    input  logic [2:0]        dmw0_pseg,
    input  logic [1:0]        dmw0_mat,
    input  logic              dmw1_en,
    input  logic [2:0]        dmw1_vseg,
    input  logic [2:0]        dmw1_pseg,
    input  logic [1:0]        dmw1_mat,
    output logic [11:0]       icache_idx,
    output logic [2:0]        icache_op,
    output logic [`INST_W-1:0] icache_pa,
    output logic              icache_is_cached,
    output logic              out_is_flush,
    output logic [`INST_W-1:0] out_pc,
    output logic [`INST_W-1:0] out_btb_pre,
    output logic              excp_valid,
    output logic [5:0]        excp_code
);
    import fetch_pkg::*;

    wr_pc_req_t  ex_req;
    wr_pc_req_t  excp_req;
    btb_update_t upd;
    csr_fetch_t  csr;
    word_t       va;
    word_t       pa;
    logic        is_cached;
    excp_pass_t  addr_excp;
    excp_pass_t  excp_pass;
    fetch_pass_t pass;
    ic_op_t      ic_op;

    btb_if btb_bus ();

    assign ex_req   = '{valid: ex_redirect_valid, pc: ex_redirect_pc};
    assign excp_req = '{valid: excp_redirect_valid, pc: excp_redirect_pc};
    assign upd      = '{valid: btb_upd_valid, pc: btb_upd_pc, target: btb_upd_target};

    assign csr.da     = csr_da;
    assign csr.dmw[0] = '{en: dmw0_en, vseg: dmw0_vseg, pseg: dmw0_pseg, mat: dmw0_mat};
    assign csr.dmw[1] = '{en: dmw1_en, vseg: dmw1_vseg, pseg: dmw1_pseg, mat: dmw1_mat};

    fetch1 u_fetch1 (
        .clk              (clk),
        .rst_n            (rst_n),
        .ex_wr_pc_req     (ex_req),
        .excp_wr_pc_req   (excp_req),
        .pa               (pa),
        .is_cached        (is_cached),
        .addr_excp        (addr_excp),
        .is_stall         (stall),
        .is_flush         (flush),
        .btb              (btb_bus.fetch),
        .va               (va),
        .icache_idx       (icache_idx),
        .icache_op        (ic_op),
        .icache_pa        (icache_pa),
        .icache_is_cached (icache_is_cached),
        .pass_out         (pass),
        .excp_pass_out    (excp_pass)
    );

    btb u_btb (
        .clk    (clk),
        .rst_n  (rst_n),
        .upd    (upd),
        .lookup (btb_bus.btb)
    );

    addr_trans u_addr_trans (
        .va        (va),
        .csr       (csr),
        .pa        (pa),
        .is_cached (is_cached),
        .excp      (addr_excp)
    );

    assign icache_op    = ic_op;
    assign out_is_flush = pass.is_flush;
    assign out_pc       = pass.pc;
    assign out_btb_pre  = pass.btb_pre;
    assign excp_valid   = excp_pass.valid;
    assign excp_code    = excp_pass.code;

endmodule

// File: logic/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Boot address of the core.
`define RESET_PC 32'h1c00_0000

// Branch target buffer geometry. The index comes from pc bits 5:2.
`define BTB_ENTRIES 16
`define BTB_IDX_W   4

// Width of an instruction word and of every address in the front end.
`define INST_W 32

`endif

// File: logic/fetch_pkg.sv
package fetch_pkg;

`include "fetch_macros.svh"

    typedef logic [`INST_W-1:0] word_t;

    typedef enum logic [2:0] {
        IC_NOP  = 3'd0,
        IC_READ = 3'd1
    } ic_op_t;

    typedef enum logic [5:0] {
        EXC_NONE = 6'h00,
        EXC_ADEF = 6'h08,  // misaligned fetch address.
        EXC_TLBR = 6'h3f   // no window matched so the tlb must be refilled.
    } excp_code_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } wr_pc_req_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t target;
    } btb_update_t;

    typedef struct packed {
        logic       en;
        logic [2:0] vseg;  // compared against va bits 31:29.
        logic [2:0] pseg;
        logic [1:0] mat;   // bit 0 set means cached.
    } dmw_t;

    typedef struct packed {
        logic       da;
        dmw_t [1:0] dmw;
    } csr_fetch_t;

    typedef struct packed {
        logic       valid;
        excp_code_t code;
    } excp_pass_t;

    typedef struct packed {
        logic  is_flush;
        word_t pc;
        word_t btb_pre;
    } fetch_pass_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module fetch_front_tb -f tb.f -o fetch_front_sim \
    > build.log 2>&1 \
    && ./obj_dir/fetch_front_sim > sim.log 2>&1 \
    && ! grep -q "Some tests failed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation or build failed, see build.log and sim.log"; exit 1; }

// File: sim/fetch_front_assert.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_front_assert (
    input logic              clk,
    input logic              rst_n,
    input fetch_pkg::word_t  pc,
    input fetch_pkg::word_t  npc,
    input logic              is_stall,
    input logic [11:0]       icache_idx,
    input fetch_pkg::ic_op_t icache_op,
    input logic              is_flush
);
    import fetch_pkg::*;

    // the first edge after reset release still sees the boot pc.
    reset_pc_check: assert property (@(posedge clk) $rose(rst_n) |-> pc == `RESET_PC)
        else $error("pc is not the boot address right after reset");

    // the index follows the pc loaded on the last unstalled edge.
    idx_check: assert property (@(posedge clk) disable iff (!rst_n)
        !is_stall |=> icache_idx == $past(npc[11:0]))
        else $error("cache index does not match the low pc bits");

    flush_check: assert property (@(posedge clk) disable iff (!rst_n)
        is_flush |-> icache_op == IC_NOP)
        else $error("cache request issued during a flush");

endmodule

bind fetch1 fetch_front_assert u_fetch_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc_r),
    .npc        (npc),
    .is_stall   (is_stall),
    .icache_idx (icache_idx),
    .icache_op  (icache_op),
    .is_flush   (is_flush)
);

// File: sim/fetch_front_tb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_front_tb;
    import fetch_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int P_SEQ   = 20;
    localparam int P_REDIR = 80;
    localparam int P_PRED  = 150;
    localparam int P_STALL = 80;
    localparam int P_TRANS = 120;
    localparam int P_FLUSH = 60;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + P_SEQ + P_REDIR + P_PRED + P_STALL
                                  + P_TRANS + P_FLUSH;
    localparam int CYCLE_LIMIT = TOTAL_CYCLES * 3 / 2;

    logic clk, rst_n, stall, flush;
    logic ex_redirect_valid, excp_redirect_valid, btb_upd_valid;
    logic [31:0] ex_redirect_pc, excp_redirect_pc, btb_upd_pc, btb_upd_target;
    logic csr_da, dmw0_en, dmw1_en;
    logic [2:0] dmw0_vseg, dmw0_pseg, dmw1_vseg, dmw1_pseg;
    logic [1:0] dmw0_mat, dmw1_mat;
    logic [11:0] icache_idx;
    logic [2:0] icache_op;
    logic [31:0] icache_pa, out_pc, out_btb_pre;
    logic icache_is_cached, out_is_flush, excp_valid;
    logic [5:0] excp_code;

    integer seed;
    int errors;
    int cycle_count = 0;

    // reference model of the pc register and of the btb with its registered prediction.
    word_t m_pc;
    logic  m_pred_valid;
    word_t m_pred_npc;
    logic  t_valid  [`BTB_ENTRIES];
    word_t t_pc     [`BTB_ENTRIES];
    word_t t_target [`BTB_ENTRIES];

    fetch_front UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Simulation timed out after %0d cycles without finishing", cycle_count);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "first mismatch in %s", name);
        end
    endtask

    function automatic bit roll(input int pct);
        logic [31:0] v;
        v = $random(seed);
        return int'(v % 32'd100) < pct;
    endfunction

    // mostly near the current pc so that btb entries get revisited.
    function automatic word_t make_pc(input int bad_pct);
        logic [31:0] r;
        word_t pc;
        r = $random(seed);
        if (roll(30)) pc = {r[31:2], 2'b00};
        else pc = {m_pc[31:10], r[9:2], 2'b00};
        if (roll(bad_pct)) pc[1:0] = {r[10], 1'b1};
        return pc;
    endfunction

    function automatic word_t next_pc();
        if (excp_redirect_valid) return excp_redirect_pc;
        if (ex_redirect_valid) return ex_redirect_pc;
        if (m_pred_valid) return m_pred_npc;
        return m_pc + 32'd4;
    endfunction

    function automatic void trans_model(input word_t va, output word_t pa,
                                        output logic cached, output logic miss);
        pa = va;
        cached = 1'b1;
        miss = 1'b0;
        if (!csr_da) begin
            if (dmw0_en && dmw0_vseg == va[31:29]) begin
                pa = {dmw0_pseg, va[28:0]};
                cached = dmw0_mat[0];
            end else if (dmw1_en && dmw1_vseg == va[31:29]) begin
                pa = {dmw1_pseg, va[28:0]};
                cached = dmw1_mat[0];
            end else begin
                cached = 1'b0;  // an unmapped fetch has no cache attribute.
                miss = 1'b1;
            end
        end
    endfunction

    task automatic check_outputs(input string name);
        word_t exp_pa;
        logic exp_cached, miss, exp_ev;
        logic [5:0] exp_code;
        logic [2:0] exp_op;
        trans_model(m_pc, exp_pa, exp_cached, miss);
        exp_op = flush ? IC_NOP : IC_READ;
        exp_ev = 1'b1;
        if (m_pc[1:0] != 2'b00) exp_code = EXC_ADEF;  // alignment wins over the mapping.
        else if (miss) exp_code = EXC_TLBR;
        else begin
            exp_code = EXC_NONE;
            exp_ev = 1'b0;
        end
        check({name, ".out_pc"}, m_pc, out_pc);
        check({name, ".out_btb_pre"}, next_pc(), out_btb_pre);
        check({name, ".icache_idx"}, {20'd0, m_pc[11:0]}, {20'd0, icache_idx});
        check({name, ".icache_op"}, {29'd0, exp_op}, {29'd0, icache_op});
        check({name, ".out_is_flush"}, {31'd0, flush}, {31'd0, out_is_flush});
        check({name, ".icache_pa"}, exp_pa, icache_pa);
        check({name, ".icache_is_cached"}, {31'd0, exp_cached}, {31'd0, icache_is_cached});
        check({name, ".excp_valid"}, {31'd0, exp_ev}, {31'd0, excp_valid});
        check({name, ".excp_code"}, {26'd0, exp_code}, {26'd0, excp_code});
    endtask

    // Applies the coming clock edge to the model. Lookups read the table before the update.
    task automatic advance_model();
        word_t npc;
        logic [`BTB_IDX_W-1:0] li;
        logic [`BTB_IDX_W-1:0] ui;
        npc = next_pc();
        li = npc[`BTB_IDX_W+1:2];
        ui = btb_upd_pc[`BTB_IDX_W+1:2];
        if (!stall) begin
            m_pred_valid = t_valid[li] && (t_pc[li] == npc);
            m_pred_npc = t_target[li];
            m_pc = npc;
        end
        if (btb_upd_valid) begin
            t_valid[ui] = 1'b1;
            t_pc[ui] = btb_upd_pc;
            t_target[ui] = btb_upd_target;
        end
    endtask

    task automatic drive_inputs(input int stall_pct, input int redir_pct, input int upd_pct,
                                input int flush_pct, input bit csr_rand, input int bad_pct);
        logic [31:0] r;
        word_t near;
        r = $random(seed);
        near = m_pc + {28'd0, r[1:0], 2'b00};
        if (r[2] && r[3]) near = near ^ 32'h0000_0400;  // same index, different pc.
        stall <= roll(stall_pct);
        flush <= roll(flush_pct);
        ex_redirect_valid <= roll(redir_pct);
        ex_redirect_pc <= make_pc(bad_pct);
        excp_redirect_valid <= roll(redir_pct / 2);
        excp_redirect_pc <= make_pc(bad_pct);
        btb_upd_valid <= roll(upd_pct);
        btb_upd_pc <= near;
        btb_upd_target <= {m_pc[31:10], r[11:4], 2'b00};
        if (csr_rand) begin
            r = $random(seed);
            csr_da <= roll(25);
            dmw0_en <= roll(70);
            dmw0_vseg <= roll(50) ? m_pc[31:29] : r[2:0];
            dmw0_pseg <= r[5:3];
            dmw0_mat <= r[7:6];
            dmw1_en <= roll(70);
            dmw1_vseg <= roll(50) ? m_pc[31:29] : r[10:8];
            dmw1_pseg <= r[13:11];
            dmw1_mat <= r[15:14];
        end
    endtask

    task automatic run_phase(input string name, input int cycles, input int stall_pct,
                             input int redir_pct, input int upd_pct, input int flush_pct,
                             input bit csr_rand, input int bad_pct);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            drive_inputs(stall_pct, redir_pct, upd_pct, flush_pct, csr_rand, bad_pct);
            @(negedge clk);  // outputs have settled here.
            check_outputs(name);
            advance_model();
        end
    endtask

    initial begin
        seed = 65;
        errors = 0;
        rst_n <= 1'b0;
        stall <= 1'b0;
        flush <= 1'b0;
        ex_redirect_valid <= 1'b0;
        ex_redirect_pc <= '0;
        excp_redirect_valid <= 1'b0;
        excp_redirect_pc <= '0;
        btb_upd_valid <= 1'b0;
        btb_upd_pc <= '0;
        btb_upd_target <= '0;
        csr_da <= 1'b1;
        {dmw0_en, dmw0_vseg, dmw0_pseg, dmw0_mat} <= '0;
        {dmw1_en, dmw1_vseg, dmw1_pseg, dmw1_mat} <= '0;
        m_pc = `RESET_PC;
        m_pred_valid = 1'b0;
        m_pred_npc = '0;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            t_valid[i] = 1'b0;
            t_pc[i] = '0;
            t_target[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("reset.boot_pc", `RESET_PC, out_pc);
        check_outputs("reset");
        advance_model();
        run_phase("sequential", P_SEQ, 0, 0, 0, 0, 1'b0, 0);
        run_phase("redirect", P_REDIR, 0, 40, 30, 0, 1'b0, 0);
        run_phase("predict", P_PRED, 0, 5, 60, 0, 1'b0, 0);
        run_phase("stall", P_STALL, 50, 20, 20, 0, 1'b0, 0);
        run_phase("translate", P_TRANS, 10, 30, 10, 0, 1'b1, 20);
        run_phase("flush", P_FLUSH, 10, 20, 20, 50, 1'b0, 0);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+logic
logic/fetch_pkg.sv
logic/btb_if.sv
logic/btb.sv
logic/addr_trans.sv
logic/fetch1.sv
logic/fetch_front.sv
sim/fetch_front_assert.sv
sim/fetch_front_tb.sv
